//--- usbTxGolden.mem
// Record line 1: kind pid addr endp len bump, then payload bytes p0..p7
// Record line 2: expected byte count after SYNC, then expected bytes e0..e10
// SETUP to address 0, endpoint 0
0 D 00 0 0 0  00 00 00 00 00 00 00 00
03 2D 00 10  00 00 00 00 00 00 00 00
// IN to address 15, endpoint E, with a second start while busy
0 9 15 E 0 1  00 00 00 00 00 00 00 00
03 69 15 EF  00 00 00 00 00 00 00 00
// OUT to address 01, endpoint 0
0 1 01 0 0 0  00 00 00 00 00 00 00 00
03 E1 01 E8  00 00 00 00 00 00 00 00
// DATA0 with no payload
1 3 00 0 0 0  00 00 00 00 00 00 00 00
03 C3 00 00  00 00 00 00 00 00 00 00
// DATA1 with one byte
1 B 00 0 1 0  FE 00 00 00 00 00 00 00
04 4B FE C1 3F  00 00 00 00 00 00 00
// DATA0 with a full payload and a second start while busy
1 3 00 0 8 1  FF FF 01 C0 00 00 00 00
0B C3 FF FF 01 C0 00 00 00 00 FE 3F
// DATA1 with all ones so that stuffing kicks in
1 B 00 0 2 0  FF FF 00 00 00 00 00 00
05 4B FF FF FF FF  00 00 00 00 00 00
// ACK
2 2 00 0 0 0  00 00 00 00 00 00 00 00
01 D2  00 00 00 00 00 00 00 00 00 00
// NAK
2 A 00 0 0 0  00 00 00 00 00 00 00 00
01 5A  00 00 00 00 00 00 00 00 00 00
// STALL
2 E 00 0 0 0  00 00 00 00 00 00 00 00
01 1E  00 00 00 00 00 00 00 00 00 00

//--- filelist.f
+incdir+.
usbTxPkg.sv
outputShiftReg.sv
usbCrcGen.sv
txPacketSequencer.sv
lineEncoder.sv
usbTxTop.sv
tbUsbTx.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tbUsbTx -Mdir obj_dir
simOut=$(./obj_dir/VtbUsbTx)
echo "$simOut"

if echo "$simOut" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

//--- tbUsbTxChecks.svh
`ifndef TB_USB_TX_CHECKS_SVH
`define TB_USB_TX_CHECKS_SVH

int errorCount;
int checkTotal;

task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checkTotal++;
    if (got !== exp) begin
        $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
        errorCount++;
    end
endtask

// Line values print as {dp, dn}
task automatic checkLine(input string name, input lineState_t got, input lineState_t exp);
    checkTotal++;
    if (got !== exp) begin
        $display("FAILED %s: got 0x%01h, expected 0x%01h", name, got, exp);
        errorCount++;
    end
endtask

task automatic checkCount(input string name, input int got, input int exp);
    checkTotal++;
    if (got != exp) begin
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errorCount++;
    end
endtask

`endif

//--- tbUsbTx.sv
`timescale 1ns/1ns

module tbUsbTx
    import usbTxPkg::*;
();

    localparam int NUM_RECORDS = 10;
    localparam int RECORD_WORDS = 26;
    localparam lineState_t LINE_K = '{dp: 1'b0, dn: 1'b1};

    logic       clk12;
    logic       rst;
    logic       txStart;
    txReq_t     txReq;
    logic [7:0] payloadByte;
    logic       byteReq;
    logic       busy;
    lineState_t line;

    `include "tbUsbTxChecks.svh"

    logic [7:0] golden [0:NUM_RECORDS*RECORD_WORDS-1];
    logic [7:0] curPayload [0:MAX_PAYLOAD-1];
    logic [7:0] rxBytes [$];
    int         pktCount;
    int         byteReqCount;
    int         cycleCount;
    int         cycleLimit;
    int         testCount;
    logic       pendingByte;
    logic       inPkt;
    lineState_t prevLine;
    int         onesRun;
    int         bitCnt;
    int         se0Cnt;
    logic [7:0] curByte;
    logic       rxBit;

    usbTxTop uut (
        .clk12_i      (clk12),
        .rst_i        (rst),
        .txStart_i    (txStart),
        .txReq_i      (txReq),
        .payloadByte_i(payloadByte),
        .byteReq_o    (byteReq),
        .busy_o       (busy),
        .line_o       (line)
    );

    always #20 clk12 = ~clk12;

    always @(posedge clk12) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    // Payload answers the request one cycle later
    always @(negedge clk12) begin
        if (!rst && byteReq) begin
            byteReqCount = byteReqCount + 1;
            pendingByte = 1'b1;
        end
    end

    always @(posedge clk12) begin
        if (pendingByte) begin
            #2;
            if (byteReqCount >= 1 && byteReqCount <= MAX_PAYLOAD) begin
                payloadByte = curPayload[byteReqCount-1];
            end
            pendingByte = 1'b0;
        end
    end

    // Line decoder that undoes NRZI and bit stuffing
    always @(negedge clk12) begin
        if (rst) begin
            inPkt = 1'b0;
            prevLine = LINE_J;
        end else if (!inPkt) begin
            if (line == LINE_K) begin
                inPkt = 1'b1;                 // First SYNC bit is a zero
                rxBytes.delete();
                curByte = 8'h00;
                bitCnt = 1;
                onesRun = 0;
                se0Cnt = 0;
                prevLine = line;
            end else if (line != LINE_J) begin
                $display("Line left idle without a K at cycle %0d", cycleCount);
                errorCount++;
            end
        end else if (line == LINE_SE0) begin
            se0Cnt++;
        end else if (se0Cnt > 0) begin
            if (bitCnt != 0) begin
                $display("Packet ended with %0d bits of a partial byte", bitCnt);
                errorCount++;
            end
            checkCount("eopSe0Cycles", se0Cnt, 2);
            checkLine("line_o", line, LINE_J);
            if (busy) begin
                $display("busy_o still high in the J cycle after EOP");
                errorCount++;
            end
            inPkt = 1'b0;
            prevLine = LINE_J;
            pktCount++;
        end else begin
            rxBit = (line == prevLine);       // No transition means a one
            prevLine = line;
            if (onesRun == 6) begin
                if (rxBit) begin
                    $display("Seven bits without a transition at cycle %0d", cycleCount);
                    errorCount++;
                end
                onesRun = 0;
            end else begin
                onesRun = rxBit ? onesRun + 1 : 0;
                curByte[bitCnt] = rxBit;
                bitCnt++;
                if (bitCnt == 8) begin
                    rxBytes.push_back(curByte);
                    bitCnt = 0;
                end
            end
        end
    end

    task automatic runRecord(input int r);
        int base;
        int expCnt;
        int errorsBefore;
        base = r * RECORD_WORDS;
        errorsBefore = errorCount;
        for (int i = 0; i < MAX_PAYLOAD; i++) begin
            curPayload[i] = golden[base+6+i];
        end
        byteReqCount = 0;
        @(posedge clk12);
        #2;
        txReq.kind = pktKind_t'(golden[base][1:0]);
        txReq.pid = pidCode_t'(golden[base+1][3:0]);
        txReq.addr = golden[base+2][6:0];
        txReq.endp = golden[base+3][3:0];
        txReq.len = golden[base+4][3:0];
        txStart = 1'b1;
        @(posedge clk12);
        #2;
        txStart = 1'b0;
        if (golden[base+5] != 8'h00) begin
            repeat (10) @(posedge clk12);
            #2;
            txReq.kind = PKT_HANDSHAKE;               // Must not replace the running packet
            txReq.pid = PID_STALL;
            txStart = 1'b1;
            @(posedge clk12);
            #2;
            txStart = 1'b0;
        end
        while (pktCount == r) begin
            @(negedge clk12);
        end
        repeat (4) begin
            @(negedge clk12);
            checkLine("line_o", line, LINE_J);
            if (busy) begin
                $display("busy_o high while the port should be idle");
                errorCount++;
            end
        end
        if (pktCount != r + 1) begin
            $display("An extra packet appeared after test %0d", r);
            errorCount++;
        end
        expCnt = golden[base+14];
        checkCount("packetBytes", rxBytes.size() - 1, expCnt);
        if (rxBytes.size() > 0) begin
            checkByte("sync", rxBytes[0], 8'h80);   // KJKJKJKK on the line
        end
        for (int i = 0; i < expCnt && i + 1 < rxBytes.size(); i++) begin
            checkByte($sformatf("byte%0d", i), rxBytes[i+1], golden[base+15+i]);
        end
        checkCount("byteReqPulses", byteReqCount, golden[base+4]);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d pid 0x%01h: ok", r, golden[base+1][3:0]);
        end else begin
            $display("Test %0d pid 0x%01h: %0d errors", r, golden[base+1][3:0],
                     errorCount - errorsBefore);
        end
    endtask

    initial begin : main
        int limit;
        clk12 = 1'b0;
        rst = 1'b1;
        txStart = 1'b0;
        txReq = '0;
        payloadByte = 8'h00;
        cycleCount = 0;
        cycleLimit = 0;
        pktCount = 0;
        byteReqCount = 0;
        testCount = 0;
        pendingByte = 1'b0;
        errorCount = 0;
        checkTotal = 0;
        $readmemh("usbTxGolden.mem", golden);
        limit = 0;
        for (int r = 0; r < NUM_RECORDS; r++) begin
            limit += 12 * 8 * (golden[r*RECORD_WORDS+14] + 1);   // SYNC plus packet bytes
        end
        cycleLimit = limit + 200;
        repeat (4) @(posedge clk12);
        #2;
        rst = 1'b0;
        @(negedge clk12);
        checkLine("line_o", line, LINE_J);
        if (busy || byteReq) begin
            $display("busy_o or byteReq_o high after reset");
            errorCount++;
        end
        for (int r = 0; r < NUM_RECORDS; r++) begin
            runRecord(r);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkTotal, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- usbTxTop.sv
`timescale 1ns/1ns

module usbTxTop
    import usbTxPkg::*;
(
    input  logic       clk12_i,
    input  logic       rst_i,
    input  logic       txStart_i,
    input  txReq_t     txReq_i,
    input  logic [7:0] payloadByte_i,
    output logic       byteReq_o,
    output logic       busy_o,
    output lineState_t line_o
);

    logic [7:0]             loadByte;
    logic                   dataValid;
    logic                   crc5Patch;
    logic                   bufferEmpty;
    logic                   crc5PatchNow;
    logic                   shiftEn;
    logic                   dataBit;
    crcMode_t               crcMode;
    logic                   crcInit;
    logic [CRC16_WIDTH-1:0] crcOut;
    logic                   pktDone;
    logic                   eopDone;

    txPacketSequencer sequencer (
        .clk12_i       (clk12_i),
        .rst_i         (rst_i),
        .txStart_i     (txStart_i),
        .txReq_i       (txReq_i),
        .payloadByte_i (payloadByte_i),
        .bufferEmpty_i (bufferEmpty),
        .crc5PatchNow_i(crc5PatchNow),
        .shiftEn_i     (shiftEn),
        .crcOut_i      (crcOut),
        .eopDone_i     (eopDone),
        .loadByte_o    (loadByte),
        .dataValid_o   (dataValid),
        .crc5Patch_o   (crc5Patch),
        .crcMode_o     (crcMode),
        .crcInit_o     (crcInit),
        .byteReq_o     (byteReq_o),
        .pktDone_o     (pktDone),
        .busy_o        (busy_o)
    );

    outputShiftReg #(
        .LENGTH(8)
    ) shifter (
        .clk12_i       (clk12_i),
        .rst_i         (rst_i),
        .en_i          (shiftEn),
        .dataValid_i   (dataValid),
        .crc5Patch_i   (crc5Patch),
        .data_i        (loadByte),
        .dataBit_o     (dataBit),
        .bufferEmpty_o (bufferEmpty),
        .crc5PatchNow_o(crc5PatchNow)
    );

    usbCrcGen crcGen (
        .clk12_i (clk12_i),
        .rst_i   (rst_i),
        .init_i  (crcInit),
        .mode_i  (crcMode),
        .bitEn_i (shiftEn),
        .bit_i   (dataBit),
        .crcOut_o(crcOut)
    );

    lineEncoder encoder (
        .clk12_i  (clk12_i),
        .rst_i    (rst_i),
        .dataBit_i(dataBit),
        .active_i (busy_o),
        .pktDone_i(pktDone),
        .shiftEn_o(shiftEn),
        .eopDone_o(eopDone),
        .line_o   (line_o)
    );

endmodule

//--- lineEncoder.sv
`timescale 1ns/1ns

module lineEncoder
    import usbTxPkg::*;
(
    input  logic       clk12_i,
    input  logic       rst_i,
    input  logic       dataBit_i,
    input  logic       active_i,
    input  logic       pktDone_i,
    output logic       shiftEn_o,
    output logic       eopDone_o,
    output lineState_t line_o
);

    localparam int ONES_W = $clog2(STUFF_LIMIT + 1);
    localparam int EOP_W = $clog2(EOP_SE0_BITS + 1);

    logic [ONES_W-1:0] onesCnt;
    logic              level;       // High means the line sits at J
    logic              eopActive;
    logic [EOP_W-1:0]  eopCnt;
    logic              stuffNow;
    lineState_t        lastLine;
    logic [2:0]        runLen;      // Line cycles without a transition

    function automatic lineState_t levelToLine(input logic lvl);
        lineState_t ls;
        ls.dp = lvl;
        ls.dn = ~lvl;
        return ls;
    endfunction

    // Six ones in a row force a zero, and the shifter holds for that cycle
    assign stuffNow = active_i && (onesCnt == ONES_W'(STUFF_LIMIT));
    assign shiftEn_o = !stuffNow;
    assign eopDone_o = active_i && eopActive && !stuffNow
                       && (eopCnt == EOP_W'(EOP_SE0_BITS));

    always_ff @(posedge clk12_i) begin
        if (rst_i || !active_i) begin
            line_o <= LINE_J;
            level <= 1'b1;
            onesCnt <= '0;
            eopActive <= 1'b0;
            eopCnt <= '0;
        end else if (stuffNow) begin
            level <= !level;   // A stuffed zero is a plain NRZI toggle
            line_o <= levelToLine(!level);
            onesCnt <= '0;
        end else if (eopActive) begin
            if (eopCnt == EOP_W'(EOP_SE0_BITS)) begin
                line_o <= LINE_J;
                level <= 1'b1;
                eopActive <= 1'b0;
                eopCnt <= '0;
            end else begin
                line_o <= LINE_SE0;
                eopCnt <= eopCnt + 1'b1;
            end
        end else begin
            if (dataBit_i) begin
                line_o <= levelToLine(level);
                onesCnt <= onesCnt + 1'b1;
            end else begin
                level <= !level;
                line_o <= levelToLine(!level);
                onesCnt <= '0;
            end
            if (pktDone_i) begin
                eopActive <= 1'b1;   // Last bit goes out now and SE0 follows any stuff bit
            end
        end
    end

    always_ff @(posedge clk12_i) begin
        lastLine <= line_o;
        if (rst_i || !active_i) begin
            runLen <= '0;
        end else if (line_o != lastLine) begin
            runLen <= '0;
        end else if (runLen != '1) begin
            runLen <= runLen + 1'b1;
        end
    end

    // Eight equal line cycles would mean a missed stuff bit
    assert property (@(posedge clk12_i) disable iff (rst_i)
        active_i |-> runLen <= 3'(STUFF_LIMIT))
        else $error("line held without transition too long");

endmodule

//--- txPacketSequencer.sv
`timescale 1ns/1ns

module txPacketSequencer
    import usbTxPkg::*;
(
    input  logic                   clk12_i,
    input  logic                   rst_i,
    input  logic                   txStart_i,
    input  txReq_t                 txReq_i,
    input  logic [7:0]             payloadByte_i,
    input  logic                   bufferEmpty_i,
    input  logic                   crc5PatchNow_i,
    input  logic                   shiftEn_i,
    input  logic [CRC16_WIDTH-1:0] crcOut_i,
    input  logic                   eopDone_i,
    output logic [7:0]             loadByte_o,
    output logic                   dataValid_o,
    output logic                   crc5Patch_o,
    output crcMode_t               crcMode_o,
    output logic                   crcInit_o,
    output logic                   byteReq_o,
    output logic                   pktDone_o,
    output logic                   busy_o
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_SYNC, ST_PID, ST_TOK1, ST_TOK2, ST_PATCH,
        ST_PAY, ST_CRC_LO, ST_CRC_HI, ST_LAST, ST_EOP
    } seqState_t;

    seqState_t  state;
    txReq_t     reqReg;
    logic [7:0] payloadReg;
    logic [3:0] payLeft;
    logic       byteWait;
    crcMode_t   modeReg;     // CRC mode of the byte now in the shifter
    logic       loadSlot;

    assign loadSlot = bufferEmpty_i && shiftEn_i;   // Last bit of the shifter leaves now
    assign busy_o = (state != ST_IDLE);
    assign crcMode_o = modeReg;

    always_comb begin
        loadByte_o = '0;
        dataValid_o = 1'b0;
        crc5Patch_o = 1'b0;
        crcInit_o = 1'b0;
        byteReq_o = 1'b0;
        pktDone_o = 1'b0;
        case (state)
            ST_SYNC: begin
                loadByte_o = SYNC_BYTE;
                dataValid_o = loadSlot;
                crcInit_o = loadSlot;
            end
            ST_PID: begin
                loadByte_o = {~reqReg.pid, reqReg.pid};   // Check nibble goes out last
                dataValid_o = loadSlot;
                byteReq_o = loadSlot && (reqReg.kind == PKT_DATA) && (reqReg.len != '0);
            end
            ST_TOK1: begin
                loadByte_o = {reqReg.endp[0], reqReg.addr};
                dataValid_o = loadSlot;
            end
            ST_TOK2: begin
                loadByte_o = {5'b11111, reqReg.endp[3:1]};   // Upper bits get patched
                dataValid_o = loadSlot;
            end
            ST_PATCH: begin
                loadByte_o = {{(8 - CRC5_RESIDUE_WIDTH){1'b1}},
                              crcOut_i[CRC5_RESIDUE_WIDTH-1:0]};
                dataValid_o = crc5PatchNow_i;
                crc5Patch_o = crc5PatchNow_i;
            end
            ST_PAY: begin
                loadByte_o = payloadReg;
                dataValid_o = loadSlot;
                byteReq_o = loadSlot && (payLeft > 4'd1);   // Fetch one byte ahead
            end
            ST_CRC_LO: begin
                loadByte_o = crcOut_i[7:0];
                dataValid_o = loadSlot;
            end
            ST_CRC_HI: begin
                loadByte_o = crcOut_i[15:8];
                dataValid_o = loadSlot;
            end
            ST_LAST: begin
                pktDone_o = loadSlot;
            end
            default: begin
                loadByte_o = '0;
            end
        endcase
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            modeReg <= CRC_NONE;
            payLeft <= '0;
            byteWait <= 1'b0;
        end else begin
            byteWait <= byteReq_o;
            case (state)
                ST_IDLE: begin
                    if (txStart_i) begin
                        state <= ST_SYNC;
                        payLeft <= txReq_i.len;
                    end
                end
                ST_SYNC: begin
                    if (dataValid_o) begin
                        state <= ST_PID;
                    end
                end
                ST_PID: begin
                    if (dataValid_o) begin
                        case (reqReg.kind)
                            PKT_TOKEN: state <= ST_TOK1;
                            PKT_DATA:  state <= (reqReg.len == '0) ? ST_CRC_LO : ST_PAY;
                            default:   state <= ST_LAST;
                        endcase
                    end
                end
                ST_TOK1: begin
                    if (dataValid_o) begin
                        state <= ST_TOK2;
                        modeReg <= CRC_5;
                    end
                end
                ST_TOK2: begin
                    if (dataValid_o) begin
                        state <= ST_PATCH;
                    end
                end
                ST_PATCH: begin
                    if (dataValid_o) begin
                        state <= ST_LAST;
                        modeReg <= CRC_NONE;
                    end
                end
                ST_PAY: begin
                    if (dataValid_o) begin
                        modeReg <= CRC_16;
                        payLeft <= payLeft - 4'd1;
                        if (payLeft == 4'd1) begin
                            state <= ST_CRC_LO;
                        end
                    end
                end
                ST_CRC_LO: begin
                    if (dataValid_o) begin
                        state <= ST_CRC_HI;
                        modeReg <= CRC_NONE;
                    end
                end
                ST_CRC_HI: begin
                    if (dataValid_o) begin
                        state <= ST_LAST;
                    end
                end
                ST_LAST: begin
                    if (pktDone_o) begin
                        state <= ST_EOP;
                    end
                end
                ST_EOP: begin
                    if (eopDone_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk12_i) begin
        if (state == ST_IDLE && txStart_i) begin
            reqReg <= txReq_i;
        end
        if (byteWait) begin
            payloadReg <= payloadByte_i;   // Byte arrives the cycle after the request
        end
    end

    assert property (@(posedge clk12_i) disable iff (rst_i) txStart_i |-> !busy_o)
        else $warning("txStart while busy is ignored");

    assert property (@(posedge clk12_i) disable iff (rst_i)
        (txStart_i && !busy_o && txReq_i.kind == PKT_DATA) |-> txReq_i.len <= MAX_PAYLOAD)
        else $error("payload length above maximum");

endmodule

//--- usbCrcGen.sv
`timescale 1ns/1ns

module usbCrcGen
    import usbTxPkg::*;
(
    input  logic                   clk12_i,
    input  logic                   rst_i,
    input  logic                   init_i,
    input  crcMode_t               mode_i,
    input  logic                   bitEn_i,
    input  logic                   bit_i,
    output logic [CRC16_WIDTH-1:0] crcOut_o
);

    logic [CRC16_WIDTH-1:0] crcReg;
    logic [CRC16_WIDTH-1:0] crcNext;
    logic                   feedback;

    // The top bit of the active width meets the incoming data bit
    assign feedback = bit_i ^ ((mode_i == CRC_5) ? crcReg[CRC5_RESIDUE_WIDTH-1]
                                                  : crcReg[CRC16_WIDTH-1]);

    // Look ahead by one bit so that a byte loaded in the same cycle
    // already sees the bit that is leaving now
    always_comb begin
        crcNext = crcReg;
        if (bitEn_i) begin
            case (mode_i)
                CRC_5: begin
                    crcNext[CRC5_RESIDUE_WIDTH-1:0] =
                        {crcReg[CRC5_RESIDUE_WIDTH-2:0], 1'b0}
                        ^ (feedback ? CRC5_POLY : '0);
                end
                CRC_16: begin
                    crcNext = {crcReg[CRC16_WIDTH-2:0], 1'b0}
                        ^ (feedback ? CRC16_POLY : '0);
                end
                default: begin
                    crcNext = crcReg;
                end
            endcase
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i || init_i) begin
            crcReg <= '1;   // Both CRCs start from all ones
        end else begin
            crcReg <= crcNext;
        end
    end

    // The wire wants the highest coefficient first, so the remainder is
    // reversed for an LSB first shifter
    always_comb begin
        crcOut_o = '0;
        if (mode_i == CRC_5) begin
            for (int i = 0; i < CRC5_RESIDUE_WIDTH; i++) begin
                crcOut_o[i] = ~crcNext[CRC5_RESIDUE_WIDTH-1-i];
            end
        end else begin
            for (int i = 0; i < CRC16_WIDTH; i++) begin
                crcOut_o[i] = ~crcNext[CRC16_WIDTH-1-i];
            end
        end
    end

endmodule

//--- outputShiftReg.sv
`timescale 1ns/1ns

module outputShiftReg
    import usbTxPkg::*;
#(
    parameter int LENGTH = 8
) (
    input  logic              clk12_i,
    input  logic              rst_i,
    input  logic              en_i,
    input  logic              dataValid_i,
    input  logic              crc5Patch_i,
    input  logic [LENGTH-1:0] data_i,
    output logic              dataBit_o,
    output logic              bufferEmpty_o,
    output logic              crc5PatchNow_o
);

    localparam int CNT_W = $clog2(LENGTH);

    logic [LENGTH-1:0] dataBuf;
    logic [CNT_W-1:0]  bitsLeft;      // Bits still to come after the one on dataBit_o
    logic [CNT_W-1:0]  stepBitsLeft;

    assign bufferEmpty_o = (bitsLeft == '0);
    assign dataBit_o = dataBuf[0];     // LSB goes out first

    // Only count down while real bits are in the buffer and the line takes one
    assign stepBitsLeft = (en_i && !bufferEmpty_o) ? bitsLeft - 1'b1 : bitsLeft;

    // The last covered bit is on the line now and the CRC5 field follows it
    assign crc5PatchNow_o = en_i && (bitsLeft == CNT_W'(CRC5_RESIDUE_WIDTH));

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            dataBuf <= '1;
            bitsLeft <= '0;
        end else if (dataValid_i) begin
            dataBuf <= data_i;
            // A patch replaces the tail of the byte already in flight
            if (crc5Patch_i) begin
                bitsLeft <= stepBitsLeft;
            end else begin
                bitsLeft <= CNT_W'(LENGTH - 1);
            end
        end else begin
            bitsLeft <= stepBitsLeft;
            if (en_i) begin
                dataBuf <= {1'b1, dataBuf[LENGTH-1:1]};   // Idle fill is all ones
            end
        end
    end

    // A load lands either on an empty buffer taking a bit or on the patch point
    assert property (@(posedge clk12_i) disable iff (rst_i)
        dataValid_i |-> (bufferEmpty_o && en_i) || (crc5Patch_i && crc5PatchNow_o))
        else $error("shift register loaded while still shifting");

endmodule

//--- usbTxPkg.sv
package usbTxPkg;

    // PID codes as they appear in the low nibble of the PID byte
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } pidCode_t;

    typedef enum logic [1:0] {
        PKT_TOKEN     = 2'd0,
        PKT_DATA      = 2'd1,
        PKT_HANDSHAKE = 2'd2
    } pktKind_t;

    typedef enum logic [1:0] {
        CRC_NONE = 2'd0,
        CRC_5    = 2'd1,
        CRC_16   = 2'd2
    } crcMode_t;

    typedef struct packed {
        pktKind_t   kind;
        pidCode_t   pid;
        logic [6:0] addr;
        logic [3:0] endp;
        logic [3:0] len;   // Payload bytes, 0 to MAX_PAYLOAD
    } txReq_t;

    typedef struct packed {
        logic dp;
        logic dn;
    } lineState_t;

    localparam logic [7:0] SYNC_BYTE = 8'h80;   // Seven zeros then a one on the wire
    localparam int MAX_PAYLOAD = 8;
    localparam int STUFF_LIMIT = 6;
    localparam int EOP_SE0_BITS = 2;
    localparam int CRC5_RESIDUE_WIDTH = 5;
    localparam int CRC16_WIDTH = 16;

    localparam logic [CRC5_RESIDUE_WIDTH-1:0] CRC5_POLY = 5'h05;
    localparam logic [CRC16_WIDTH-1:0] CRC16_POLY = 16'h8005;

    localparam lineState_t LINE_J = '{dp: 1'b1, dn: 1'b0};
    localparam lineState_t LINE_SE0 = '{dp: 1'b0, dn: 1'b0};

endpackage
